// File: alu_reg_md_iq_top.sv
// ----------------------------------------------------------------------
// issue queue top: dispatch register, entry array and select stage
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module alu_reg_md_iq_top (
	input  logic CLK,
	input  logic nRST,
	// dispatch by way
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_attempt_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_valid_alu_reg_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_valid_mul_div_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::OP_WIDTH-1:0]        dispatch_op_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_A_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_A_ready_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_B_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_B_ready_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_dest_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_ROB_ENTRIES-1:0] dispatch_ROB_index_by_way,
	output logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_ready_advertisement,
	// pipeline levels and writeback bus
	input  logic                                                          alu_reg_pipeline_ready,
	input  logic                                                          mul_div_pipeline_ready,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0]                             WB_bus_valid_by_bank,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0][iq_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,
	// alu reg-reg issue and read requests
	output logic                                  issue_alu_reg_valid,
	output logic [iq_pkg::OP_WIDTH-1:0]           issue_alu_reg_op,
	output logic                                  issue_alu_reg_A_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_alu_reg_A_bank,
	output logic                                  issue_alu_reg_B_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_alu_reg_B_bank,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       issue_alu_reg_dest_PR,
	output logic [iq_pkg::LOG_ROB_ENTRIES-1:0]    issue_alu_reg_ROB_index,
	output logic                                  PRF_alu_reg_req_A_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_alu_reg_req_A_PR,
	output logic                                  PRF_alu_reg_req_B_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_alu_reg_req_B_PR,
	// mul/div issue and read requests
	output logic                                  issue_mul_div_valid,
	output logic [iq_pkg::OP_WIDTH-1:0]           issue_mul_div_op,
	output logic                                  issue_mul_div_A_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_mul_div_A_bank,
	output logic                                  issue_mul_div_B_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_mul_div_B_bank,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       issue_mul_div_dest_PR,
	output logic [iq_pkg::LOG_ROB_ENTRIES-1:0]    issue_mul_div_ROB_index,
	output logic                                  PRF_mul_div_req_A_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_mul_div_req_A_PR,
	output logic                                  PRF_mul_div_req_B_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_mul_div_req_B_PR
);
	import iq_pkg::*;

	// free entries after this cycle's issues and inserts
	logic [LOG_IQ_ENTRIES:0] free_count;

	iq_dispatch_if dispatch_bus ();
	iq_view_if     view_bus ();

	iq_dispatch u_dispatch (
		.disp (dispatch_bus),
		.*
	);

	iq_entry_array u_entry_array (
		.disp (dispatch_bus),
		.view (view_bus),
		.*
	);

	iq_select u_select (
		.view (view_bus),
		.*
	);

endmodule

// File: filelist.f
iq_pkg.sv
iq_intf.sv
iq_dispatch.sv
iq_entry_array.sv
iq_select.sv
alu_reg_md_iq_top.sv
tb_alu_reg_md_iq.sv

// File: iq_dispatch.sv
// ----------------------------------------------------------------------
// dispatch register stage: accept mask, bundle register and
// the registered free-space advertisement
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module iq_dispatch (
	input  logic CLK,
	input  logic nRST,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_attempt_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_valid_alu_reg_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_valid_mul_div_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::OP_WIDTH-1:0]        dispatch_op_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_A_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_A_ready_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_B_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_B_ready_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_PR_COUNT-1:0]    dispatch_dest_PR_by_way,
	input  logic [iq_pkg::DISPATCH_WAYS-1:0][iq_pkg::LOG_ROB_ENTRIES-1:0] dispatch_ROB_index_by_way,
	input  logic [iq_pkg::LOG_IQ_ENTRIES:0]                               free_count,
	output logic [iq_pkg::DISPATCH_WAYS-1:0]                              dispatch_ready_advertisement,
	iq_dispatch_if.source                                                 disp
);
	import iq_pkg::*;

	logic [DISPATCH_WAYS-1:0]  accepted;
	logic [LOG_IQ_ENTRIES:0]   accepted_count;
	logic [LOG_IQ_ENTRIES:0]   free_after;
	logic [DISPATCH_WAYS-1:0]  advertisement_next;

	// room advertised last cycle, and exactly one pipe named
	assign accepted = dispatch_attempt_by_way & dispatch_ready_advertisement
		& (dispatch_valid_alu_reg_by_way ^ dispatch_valid_mul_div_by_way);

	always_comb begin
		accepted_count = '0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			accepted_count = accepted_count + (LOG_IQ_ENTRIES+1)'(accepted[w]);
		end
		// free_count already holds this cycle's issues and array inserts
		free_after = free_count - accepted_count;
		for (int i = 0; i < DISPATCH_WAYS; i++) begin
			advertisement_next[i] = free_after > (LOG_IQ_ENTRIES+1)'(i);
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			dispatch_ready_advertisement <= '0;
			disp.accepted_by_way <= '0;
		end else begin
			dispatch_ready_advertisement <= advertisement_next;
			disp.accepted_by_way <= accepted;
		end
	end

	// ----------------------------------------------------------------------
	// op payload, only meaningful under the accepted mask
	always_ff @(posedge CLK) begin
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			disp.pipe_by_way[w] <= dispatch_valid_mul_div_by_way[w] ? PIPE_MUL_DIV : PIPE_ALU_REG;
			disp.op_by_way[w] <= iq_op_t'(dispatch_op_by_way[w]);
		end
		disp.A_PR_by_way <= dispatch_A_PR_by_way;
		disp.A_ready_by_way <= dispatch_A_ready_by_way;
		disp.B_PR_by_way <= dispatch_B_PR_by_way;
		disp.B_ready_by_way <= dispatch_B_ready_by_way;
		disp.dest_PR_by_way <= dispatch_dest_PR_by_way;
		disp.ROB_index_by_way <= dispatch_ROB_index_by_way;
	end

endmodule

// File: iq_entry_array.sv
// ----------------------------------------------------------------------
// age-ordered entry storage: issue removal, compaction,
// in-order append of accepted ways and writeback wakeup
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module iq_entry_array (
	input  logic CLK,
	input  logic nRST,
	iq_dispatch_if.sink disp,
	iq_view_if.array    view,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0]                             WB_bus_valid_by_bank,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0][iq_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,
	output logic [iq_pkg::LOG_IQ_ENTRIES:0]                               free_count
);
	import iq_pkg::*;

	iq_entry_t [IQ_ENTRIES-1:0] entries;
	iq_entry_t [IQ_ENTRIES-1:0] entries_next;
	logic [IQ_ENTRIES-1:0]      issued;

	// a waiting operand goes ready when its PR shows up on the bus
	function automatic iq_entry_t wake(input iq_entry_t e);
		iq_entry_t woken;
		woken = e;
		woken.A_ready = e.A_ready
			| wb_match(e.A_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
		woken.B_ready = e.B_ready
			| wb_match(e.B_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
		return woken;
	endfunction

	assign issued = view.issue_alu_reg_one_hot | view.issue_mul_div_one_hot;
	assign view.entry_by_index = entries;

	always_comb begin
		int unsigned fill;
		iq_entry_t   incoming;
		fill = 0;
		entries_next = '0;

		// survivors slide toward index 0, age order kept
		for (int j = 0; j < IQ_ENTRIES; j++) begin
			if (entries[j].valid && !issued[j]) begin
				entries_next[fill] = wake(entries[j]);
				fill++;
			end
		end

		// accepted ways go behind them, lowest way first
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			incoming.valid = 1'b1;
			incoming.pipe = disp.pipe_by_way[w];
			incoming.op = disp.op_by_way[w];
			incoming.A_PR = disp.A_PR_by_way[w];
			incoming.A_ready = disp.A_ready_by_way[w];
			incoming.B_PR = disp.B_PR_by_way[w];
			incoming.B_ready = disp.B_ready_by_way[w];
			incoming.dest_PR = disp.dest_PR_by_way[w];
			incoming.ROB_index = disp.ROB_index_by_way[w];
			// advertisement keeps fill below the depth here
			if (disp.accepted_by_way[w] && fill < IQ_ENTRIES) begin
				entries_next[fill] = wake(incoming);
				fill++;
			end
		end

		free_count = (LOG_IQ_ENTRIES+1)'(IQ_ENTRIES - fill);
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			entries <= '0;
		end else begin
			entries <= entries_next;
		end
	end

endmodule

// File: iq_intf.sv
// ----------------------------------------------------------------------
// dispatch bundle from the dispatch register to the entry array,
// and the queue view shared by the entry array and the select stage
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface iq_dispatch_if;
	import iq_pkg::*;

	logic [DISPATCH_WAYS-1:0]                      accepted_by_way;
	iq_pipe_t [DISPATCH_WAYS-1:0]                  pipe_by_way;
	iq_op_t [DISPATCH_WAYS-1:0]                    op_by_way;
	logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0]    A_PR_by_way;
	logic [DISPATCH_WAYS-1:0]                      A_ready_by_way;
	logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0]    B_PR_by_way;
	logic [DISPATCH_WAYS-1:0]                      B_ready_by_way;
	logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0]    dest_PR_by_way;
	logic [DISPATCH_WAYS-1:0][LOG_ROB_ENTRIES-1:0] ROB_index_by_way;

	modport source (
		output accepted_by_way, pipe_by_way, op_by_way, A_PR_by_way, A_ready_by_way,
		output B_PR_by_way, B_ready_by_way, dest_PR_by_way, ROB_index_by_way
	);

	modport sink (
		input accepted_by_way, pipe_by_way, op_by_way, A_PR_by_way, A_ready_by_way,
		input B_PR_by_way, B_ready_by_way, dest_PR_by_way, ROB_index_by_way
	);
endinterface

interface iq_view_if;
	import iq_pkg::*;

	// index 0 is the oldest entry
	iq_entry_t [IQ_ENTRIES-1:0] entry_by_index;
	logic [IQ_ENTRIES-1:0]      issue_alu_reg_one_hot;
	logic [IQ_ENTRIES-1:0]      issue_mul_div_one_hot;

	modport array (output entry_by_index, input issue_alu_reg_one_hot, issue_mul_div_one_hot);
	modport select (input entry_by_index, output issue_alu_reg_one_hot, issue_mul_div_one_hot);
endinterface

// File: iq_pkg.sv
// ----------------------------------------------------------------------
// issue queue sizes, op-code and pipeline enums, entry struct
// and the writeback bus match helper
// ----------------------------------------------------------------------

package iq_pkg;

	// ----------------------------------------------------------------------
	// sizes
	localparam int DISPATCH_WAYS      = 4;
	localparam int IQ_ENTRIES         = 8;
	localparam int LOG_IQ_ENTRIES     = 3;
	localparam int LOG_PR_COUNT       = 7;
	localparam int PRF_BANK_COUNT     = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int UPPER_PR_WIDTH     = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
	localparam int LOG_ROB_ENTRIES    = 7;
	localparam int OP_WIDTH           = 4;
	localparam int PIPE_COUNT         = 2;

	// low eight slots are shared, the pipe tag picks alu or mul/div meaning
	typedef enum logic [OP_WIDTH-1:0] {
		OP_ADD_MUL, OP_SLL_MULH, OP_SLT_MULHSU, OP_SLTU_MULHU,
		OP_XOR_DIV, OP_SRL_DIVU, OP_OR_REM, OP_AND_REMU,
		OP_SUB, OP_RSV_9, OP_RSV_A, OP_RSV_B,
		OP_RSV_C, OP_SRA, OP_RSV_E, OP_RSV_F
	} iq_op_t;

	typedef enum logic {
		PIPE_ALU_REG,
		PIPE_MUL_DIV
	} iq_pipe_t;

	typedef struct packed {
		logic                       valid;
		iq_pipe_t                   pipe;
		iq_op_t                     op;
		logic [LOG_PR_COUNT-1:0]    A_PR;
		logic                       A_ready;
		logic [LOG_PR_COUNT-1:0]    B_PR;
		logic                       B_ready;
		logic [LOG_PR_COUNT-1:0]    dest_PR;
		logic [LOG_ROB_ENTRIES-1:0] ROB_index;
	} iq_entry_t;

	// bank is the low PR bits, the bus carries the upper part per bank
	function automatic logic wb_match(
		input logic [LOG_PR_COUNT-1:0]                        pr,
		input logic [PRF_BANK_COUNT-1:0]                      wb_valid,
		input logic [PRF_BANK_COUNT-1:0][UPPER_PR_WIDTH-1:0]  wb_upper
	);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return wb_valid[bank] && (wb_upper[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

endpackage

// File: iq_select.sv
// ----------------------------------------------------------------------
// oldest-first pick per pipeline, forward flags and banks,
// registered issue and register-file read requests
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module iq_select (
	input  logic CLK,
	input  logic nRST,
	iq_view_if.select view,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0]                             WB_bus_valid_by_bank,
	input  logic [iq_pkg::PRF_BANK_COUNT-1:0][iq_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,
	input  logic                                                          alu_reg_pipeline_ready,
	input  logic                                                          mul_div_pipeline_ready,
	output logic                                  issue_alu_reg_valid,
	output logic [iq_pkg::OP_WIDTH-1:0]           issue_alu_reg_op,
	output logic                                  issue_alu_reg_A_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_alu_reg_A_bank,
	output logic                                  issue_alu_reg_B_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_alu_reg_B_bank,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       issue_alu_reg_dest_PR,
	output logic [iq_pkg::LOG_ROB_ENTRIES-1:0]    issue_alu_reg_ROB_index,
	output logic                                  PRF_alu_reg_req_A_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_alu_reg_req_A_PR,
	output logic                                  PRF_alu_reg_req_B_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_alu_reg_req_B_PR,
	output logic                                  issue_mul_div_valid,
	output logic [iq_pkg::OP_WIDTH-1:0]           issue_mul_div_op,
	output logic                                  issue_mul_div_A_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_mul_div_A_bank,
	output logic                                  issue_mul_div_B_forward,
	output logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] issue_mul_div_B_bank,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       issue_mul_div_dest_PR,
	output logic [iq_pkg::LOG_ROB_ENTRIES-1:0]    issue_mul_div_ROB_index,
	output logic                                  PRF_mul_div_req_A_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_mul_div_req_A_PR,
	output logic                                  PRF_mul_div_req_B_valid,
	output logic [iq_pkg::LOG_PR_COUNT-1:0]       PRF_mul_div_req_B_PR
);
	import iq_pkg::*;

	logic [PIPE_COUNT-1:0]                 pipe_ready;
	logic [PIPE_COUNT-1:0][IQ_ENTRIES-1:0] pick_one_hot;
	iq_entry_t [PIPE_COUNT-1:0]            pick_entry;
	logic [PIPE_COUNT-1:0]                 pick_A_forward;
	logic [PIPE_COUNT-1:0]                 pick_B_forward;

	logic [PIPE_COUNT-1:0]      issue_valid_q;
	logic [PIPE_COUNT-1:0]      req_A_valid_q;
	logic [PIPE_COUNT-1:0]      req_B_valid_q;
	iq_entry_t [PIPE_COUNT-1:0] issue_entry_q;
	logic [PIPE_COUNT-1:0]      A_forward_q;
	logic [PIPE_COUNT-1:0]      B_forward_q;

	assign pipe_ready = {mul_div_pipeline_ready, alu_reg_pipeline_ready};

	// ----------------------------------------------------------------------
	// pickers: scan from the youngest so the oldest eligible entry wins
	always_comb begin
		iq_entry_t e;
		logic      A_hit;
		logic      B_hit;
		for (int p = 0; p < PIPE_COUNT; p++) begin
			pick_one_hot[p] = '0;
			pick_entry[p] = '0;
			pick_A_forward[p] = 1'b0;
			pick_B_forward[p] = 1'b0;
			for (int j = IQ_ENTRIES - 1; j >= 0; j--) begin
				e = view.entry_by_index[j];
				A_hit = wb_match(e.A_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
				B_hit = wb_match(e.B_PR, WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
				if (e.valid && e.pipe == iq_pipe_t'(p) && pipe_ready[p]
					&& (e.A_ready || A_hit) && (e.B_ready || B_hit)) begin
					pick_one_hot[p] = '0;
					pick_one_hot[p][j] = 1'b1;
					pick_entry[p] = e;
					// not stored ready, so it came off the bus this cycle
					pick_A_forward[p] = !e.A_ready;
					pick_B_forward[p] = !e.B_ready;
				end
			end
		end
	end

	assign view.issue_alu_reg_one_hot = pick_one_hot[PIPE_ALU_REG];
	assign view.issue_mul_div_one_hot = pick_one_hot[PIPE_MUL_DIV];

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			issue_valid_q <= '0;
			req_A_valid_q <= '0;
			req_B_valid_q <= '0;
		end else begin
			for (int p = 0; p < PIPE_COUNT; p++) begin
				issue_valid_q[p] <= pick_entry[p].valid;
				req_A_valid_q[p] <= pick_entry[p].valid & ~pick_A_forward[p];
				req_B_valid_q[p] <= pick_entry[p].valid & ~pick_B_forward[p];
			end
		end
	end

	always_ff @(posedge CLK) begin
		issue_entry_q <= pick_entry;
		A_forward_q <= pick_A_forward;
		B_forward_q <= pick_B_forward;
	end

	// ----------------------------------------------------------------------
	// output fields, bank is the low PR bits
	assign issue_alu_reg_valid = issue_valid_q[PIPE_ALU_REG];
	assign issue_alu_reg_op = issue_entry_q[PIPE_ALU_REG].op;
	assign issue_alu_reg_A_forward = A_forward_q[PIPE_ALU_REG];
	assign issue_alu_reg_A_bank = issue_entry_q[PIPE_ALU_REG].A_PR[LOG_PRF_BANK_COUNT-1:0];
	assign issue_alu_reg_B_forward = B_forward_q[PIPE_ALU_REG];
	assign issue_alu_reg_B_bank = issue_entry_q[PIPE_ALU_REG].B_PR[LOG_PRF_BANK_COUNT-1:0];
	assign issue_alu_reg_dest_PR = issue_entry_q[PIPE_ALU_REG].dest_PR;
	assign issue_alu_reg_ROB_index = issue_entry_q[PIPE_ALU_REG].ROB_index;
	assign PRF_alu_reg_req_A_valid = req_A_valid_q[PIPE_ALU_REG];
	assign PRF_alu_reg_req_A_PR = issue_entry_q[PIPE_ALU_REG].A_PR;
	assign PRF_alu_reg_req_B_valid = req_B_valid_q[PIPE_ALU_REG];
	assign PRF_alu_reg_req_B_PR = issue_entry_q[PIPE_ALU_REG].B_PR;

	assign issue_mul_div_valid = issue_valid_q[PIPE_MUL_DIV];
	assign issue_mul_div_op = issue_entry_q[PIPE_MUL_DIV].op;
	assign issue_mul_div_A_forward = A_forward_q[PIPE_MUL_DIV];
	assign issue_mul_div_A_bank = issue_entry_q[PIPE_MUL_DIV].A_PR[LOG_PRF_BANK_COUNT-1:0];
	assign issue_mul_div_B_forward = B_forward_q[PIPE_MUL_DIV];
	assign issue_mul_div_B_bank = issue_entry_q[PIPE_MUL_DIV].B_PR[LOG_PRF_BANK_COUNT-1:0];
	assign issue_mul_div_dest_PR = issue_entry_q[PIPE_MUL_DIV].dest_PR;
	assign issue_mul_div_ROB_index = issue_entry_q[PIPE_MUL_DIV].ROB_index;
	assign PRF_mul_div_req_A_valid = req_A_valid_q[PIPE_MUL_DIV];
	assign PRF_mul_div_req_A_PR = issue_entry_q[PIPE_MUL_DIV].A_PR;
	assign PRF_mul_div_req_B_valid = req_B_valid_q[PIPE_MUL_DIV];
	assign PRF_mul_div_req_B_PR = issue_entry_q[PIPE_MUL_DIV].B_PR;

endmodule

// File: tb_alu_reg_md_iq.sv
// ----------------------------------------------------------------------
// testbench for the issue queue: clock, reset, directed and random
// stimulus, reference queue model and output checks
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_alu_reg_md_iq;
	import iq_pkg::*;

	logic CLK;
	logic nRST;
	logic [3:0]      attempt, v_alu, v_md, a_rdy, b_rdy, adv;
	logic [3:0][3:0] op_in;
	logic [3:0][6:0] a_pr, b_pr, dest_pr, rob_idx;
	logic            alu_ready, md_ready;
	logic [3:0]      wb_valid;
	logic [3:0][4:0] wb_upper;
	logic [1:0]      iv, fa, fb, rav, rbv;
	logic [1:0][3:0] iop;
	logic [1:0][1:0] ab, bb;
	logic [1:0][6:0] idest, irob, rap, rbp;

	// reference model state
	iq_entry_t model_q[$];
	iq_entry_t disp_reg[4];
	logic [3:0] disp_acc;
	logic [3:0] adv_model;
	logic [1:0] exp_valid, exp_fa, exp_fb;
	iq_entry_t exp_entry[2];
	int accepted_total, issued_total;
	string cur_test;

	alu_reg_md_iq_top uut (
		.CLK(CLK), .nRST(nRST),
		.dispatch_attempt_by_way(attempt), .dispatch_valid_alu_reg_by_way(v_alu),
		.dispatch_valid_mul_div_by_way(v_md), .dispatch_op_by_way(op_in),
		.dispatch_A_PR_by_way(a_pr), .dispatch_A_ready_by_way(a_rdy),
		.dispatch_B_PR_by_way(b_pr), .dispatch_B_ready_by_way(b_rdy),
		.dispatch_dest_PR_by_way(dest_pr), .dispatch_ROB_index_by_way(rob_idx),
		.dispatch_ready_advertisement(adv),
		.alu_reg_pipeline_ready(alu_ready), .mul_div_pipeline_ready(md_ready),
		.WB_bus_valid_by_bank(wb_valid), .WB_bus_upper_PR_by_bank(wb_upper),
		.issue_alu_reg_valid(iv[0]), .issue_alu_reg_op(iop[0]),
		.issue_alu_reg_A_forward(fa[0]), .issue_alu_reg_A_bank(ab[0]),
		.issue_alu_reg_B_forward(fb[0]), .issue_alu_reg_B_bank(bb[0]),
		.issue_alu_reg_dest_PR(idest[0]), .issue_alu_reg_ROB_index(irob[0]),
		.PRF_alu_reg_req_A_valid(rav[0]), .PRF_alu_reg_req_A_PR(rap[0]),
		.PRF_alu_reg_req_B_valid(rbv[0]), .PRF_alu_reg_req_B_PR(rbp[0]),
		.issue_mul_div_valid(iv[1]), .issue_mul_div_op(iop[1]),
		.issue_mul_div_A_forward(fa[1]), .issue_mul_div_A_bank(ab[1]),
		.issue_mul_div_B_forward(fb[1]), .issue_mul_div_B_bank(bb[1]),
		.issue_mul_div_dest_PR(idest[1]), .issue_mul_div_ROB_index(irob[1]),
		.PRF_mul_div_req_A_valid(rav[1]), .PRF_mul_div_req_A_PR(rap[1]),
		.PRF_mul_div_req_B_valid(rbv[1]), .PRF_mul_div_req_B_PR(rbp[1])
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	// bank from the low two PR bits, upper five bits on that bank
	function automatic logic bus_hit(input logic [6:0] pr);
		return wb_valid[pr[1:0]] && (wb_upper[pr[1:0]] == pr[6:2]);
	endfunction

	task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("%s: timed out waiting for %s", cur_test, what);
		$display("Test failed");
		$fatal(1);
	endtask

	// model of one clock edge, using the inputs driven for it
	task automatic model_update();
		int pick[2];
		iq_entry_t e;
		iq_entry_t nq[$];
		logic [1:0] lvl;
		logic [3:0] acc;
		int acc_n;
		int free_n;
		lvl = {md_ready, alu_ready};
		for (int p = 0; p < 2; p++) begin
			pick[p] = -1;
			for (int j = 0; j < model_q.size(); j++) begin
				e = model_q[j];
				if (pick[p] < 0 && lvl[p] && e.pipe == (p ? PIPE_MUL_DIV : PIPE_ALU_REG)
					&& (e.A_ready || bus_hit(e.A_PR)) && (e.B_ready || bus_hit(e.B_PR)))
					pick[p] = j;
			end
			exp_valid[p] = pick[p] >= 0;
			if (pick[p] >= 0) begin
				exp_entry[p] = model_q[pick[p]];
				// forwarded when taken off the bus, not stored ready
				exp_fa[p] = !exp_entry[p].A_ready && bus_hit(exp_entry[p].A_PR);
				exp_fb[p] = !exp_entry[p].B_ready && bus_hit(exp_entry[p].B_PR);
			end
		end
		for (int j = 0; j < model_q.size(); j++) begin
			if (j != pick[0] && j != pick[1]) begin
				e = model_q[j];
				e.A_ready = e.A_ready | bus_hit(e.A_PR);
				e.B_ready = e.B_ready | bus_hit(e.B_PR);
				nq.push_back(e);
			end
		end
		for (int w = 0; w < 4; w++) begin
			if (disp_acc[w]) begin
				e = disp_reg[w];
				e.A_ready = e.A_ready | bus_hit(e.A_PR);
				e.B_ready = e.B_ready | bus_hit(e.B_PR);
				nq.push_back(e);
			end
		end
		acc = attempt & adv_model & (v_alu ^ v_md);
		acc_n = $countones(acc);
		free_n = IQ_ENTRIES - nq.size() - acc_n;
		for (int i = 0; i < 4; i++) adv_model[i] = free_n > i;
		for (int w = 0; w < 4; w++) begin
			disp_reg[w] = '0;
			disp_reg[w].valid = 1'b1;
			disp_reg[w].pipe = v_md[w] ? PIPE_MUL_DIV : PIPE_ALU_REG;
			disp_reg[w].op = iq_op_t'(op_in[w]);
			disp_reg[w].A_PR = a_pr[w];
			disp_reg[w].A_ready = a_rdy[w];
			disp_reg[w].B_PR = b_pr[w];
			disp_reg[w].B_ready = b_rdy[w];
			disp_reg[w].dest_PR = dest_pr[w];
			disp_reg[w].ROB_index = rob_idx[w];
		end
		disp_acc = acc;
		accepted_total += acc_n;
		model_q = nq;
	endtask

	task automatic check_outputs();
		expect_equal("advertisement", adv_model, adv);
		for (int p = 0; p < 2; p++) begin
			expect_equal(p ? "md valid" : "alu valid", exp_valid[p], iv[p]);
			if (iv[p]) begin
				issued_total++;
			end
			if (exp_valid[p]) begin
				expect_equal("op", exp_entry[p].op, iop[p]);
				expect_equal("dest PR", exp_entry[p].dest_PR, idest[p]);
				expect_equal("ROB index", exp_entry[p].ROB_index, irob[p]);
				expect_equal("A forward", exp_fa[p], fa[p]);
				expect_equal("B forward", exp_fb[p], fb[p]);
				expect_equal("A bank", exp_entry[p].A_PR[1:0], ab[p]);
				expect_equal("B bank", exp_entry[p].B_PR[1:0], bb[p]);
				expect_equal("A req valid", !exp_fa[p], rav[p]);
				expect_equal("B req valid", !exp_fb[p], rbv[p]);
				expect_equal("A req PR", exp_entry[p].A_PR, rap[p]);
				expect_equal("B req PR", exp_entry[p].B_PR, rbp[p]);
			end else begin
				expect_equal("A req idle", 0, rav[p]);
				expect_equal("B req idle", 0, rbv[p]);
			end
		end
	endtask

	// inputs stay as driven at this falling edge until the next one
	task automatic run_cycle();
		model_update();
		@(negedge CLK);
		check_outputs();
	endtask

	task automatic clear_inputs();
		attempt = '0;
		v_alu = '0;
		v_md = '0;
		op_in = '0;
		a_pr = '0;
		a_rdy = '0;
		b_pr = '0;
		b_rdy = '0;
		dest_pr = '0;
		rob_idx = '0;
		wb_valid = '0;
		wb_upper = '0;
	endtask

	task automatic offer(input int w, input logic md, input logic [3:0] op,
		input logic [6:0] apr, input logic ardy, input logic [6:0] bpr, input logic brdy,
		input logic [6:0] dest, input logic [6:0] rob);
		attempt[w] = 1'b1;
		v_alu[w] = !md;
		v_md[w] = md;
		op_in[w] = op;
		a_pr[w] = apr;
		a_rdy[w] = ardy;
		b_pr[w] = bpr;
		b_rdy[w] = brdy;
		dest_pr[w] = dest;
		rob_idx[w] = rob;
	endtask

	task automatic wait_issue(input int p, input int limit);
		int n;
		n = 0;
		do begin
			run_cycle();
			n++;
			if (n > limit) fail_timeout("an issue");
		end while (!iv[p]);
	endtask

	// sweep every upper PR value over all banks so waiting ops wake
	task automatic drain();
		int n;
		clear_inputs();
		alu_ready = 1'b1;
		md_ready = 1'b1;
		n = 0;
		while (model_q.size() != 0 || disp_acc != 0 || exp_valid != 0) begin
			wb_valid = '1;
			for (int b = 0; b < 4; b++) wb_upper[b] = 5'(n + b);
			run_cycle();
			n++;
			if (n > 100) fail_timeout("the queue to drain");
		end
		clear_inputs();
	endtask

	initial begin
		int n;
		void'($urandom(32'hfa3906b7));
		clear_inputs();
		nRST = 1'b0;
		alu_ready = 1'b0;
		md_ready = 1'b0;
		disp_acc = '0;
		adv_model = '0;
		exp_valid = '0;
		accepted_total = 0;
		issued_total = 0;

		// ------------------------------------------------------------------
		cur_test = "reset";
		repeat (8) begin
			@(negedge CLK);
			expect_equal("valids in reset", 0, {iv, rav, rbv, adv});
		end
		nRST = 1'b1;
		run_cycle();
		expect_equal("advertisement after reset", 4'hf, adv);

		cur_test = "ready op";
		alu_ready = 1'b1;
		md_ready = 1'b1;
		offer(0, 1'b0, 4'h3, 7'd10, 1'b1, 7'd21, 1'b1, 7'd40, 7'd5);
		offer(1, 1'b1, 4'h4, 7'd33, 1'b1, 7'd34, 1'b1, 7'd41, 7'd6);
		run_cycle();
		clear_inputs();
		wait_issue(0, 6);
		drain();

		cur_test = "wakeup forward";
		offer(0, 1'b0, 4'h7, 7'h2d, 1'b0, 7'd12, 1'b1, 7'd50, 7'd9);
		run_cycle();
		clear_inputs();
		repeat (5) run_cycle();
		wb_valid[1] = 1'b1;
		wb_upper[1] = 5'd11;
		wait_issue(0, 3);
		clear_inputs();
		drain();

		cur_test = "back-pressure";
		alu_ready = 1'b0;
		md_ready = 1'b0;
		for (int w = 0; w < 4; w++) offer(w, 1'b0, 4'(w), 7'(w), 1'b1, 7'(w + 8), 1'b1, 7'(w), 7'(w));
		run_cycle();
		for (int w = 0; w < 4; w++) offer(w, 1'b1, 4'(w), 7'(w), 1'b1, 7'(w), 1'b1, 7'(w), 7'(w + 4));
		run_cycle();
		clear_inputs();
		repeat (4) run_cycle();
		alu_ready = 1'b1;
		repeat (3) run_cycle();
		md_ready = 1'b1;
		repeat (6) run_cycle();
		drain();

		cur_test = "fill";
		alu_ready = 1'b0;
		md_ready = 1'b0;
		n = 0;
		do begin
			for (int w = 0; w < 4; w++) offer(w, w[0], 4'h1, 7'(n), 1'b1, 7'(w), 1'b1, 7'(n), 7'(w));
			run_cycle();
			n++;
			if (n > 10) fail_timeout("the advertisement to reach zero");
		end while (adv != 0);
		repeat (2) run_cycle();
		drain();
		expect_equal("issued equals accepted", accepted_total, issued_total);

		cur_test = "random";
		for (int c = 0; c < 400; c++) begin
			attempt = 4'($urandom);
			v_alu = 4'($urandom);
			v_md = 4'($urandom);
			op_in = 16'($urandom);
			a_pr = 28'($urandom);
			b_pr = 28'($urandom);
			a_rdy = 4'($urandom) | 4'($urandom);
			b_rdy = 4'($urandom) | 4'($urandom);
			dest_pr = 28'($urandom);
			rob_idx = 28'($urandom);
			wb_valid = 4'($urandom);
			wb_upper = 20'($urandom);
			alu_ready = ($urandom % 4) != 0;
			md_ready = ($urandom % 3) != 0;
			run_cycle();
		end
		drain();
		expect_equal("issued equals accepted", accepted_total, issued_total);

		$display("Test passed");
		$finish;
	end

endmodule
